// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Program counter in words, byte address bits 31 down to 2
    typedef logic [29:0] pc_word_t;

    // Byte address presented to instruction memory
    typedef logic [31:0] paddr_t;

    // One instruction word as returned by memory
    typedef logic [31:0] instr_t;

    // Request sequencer states
    typedef enum logic [1:0] {
        // Bus quiet, no transaction open
        IDLE    = 2'd0,
        // Req high, waiting for ack to rise
        REQ     = 2'd1,
        // Req low, waiting for ack to fall
        RELEASE = 2'd2,
        // Timed out with req low, draining any late ack
        ABORT   = 2'd3
    } fetch_state_e;

    // Memory content rule shared by the testbench memory and checker
    // Word at byte address A holds A ^ MEM_SALT
    localparam logic [31:0] MEM_SALT = 32'hA5C3_0F69;

endpackage : fetch_pkg

`default_nettype wire

// ==== fetch_stage_f1.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage_f1 #(
    // Word address loaded on reset
    parameter fetch_pkg::pc_word_t RESET_PC_WORD = 30'h0
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,

    // Branch redirect from later stages
    input  wire logic                i_redirect,
    input  wire fetch_pkg::pc_word_t i_redirect_pc_word,

    // Pulse from the sequencer when it issues a request
    input  wire logic                i_pc_advance,

    // Base-offset remap controls
    input  wire logic                i_xlate_en,
    input  wire fetch_pkg::pc_word_t i_xlate_base_word,

    // Current pc and its fetch address toward the sequencer
    output fetch_pkg::pc_word_t      o_pc_word,
    output fetch_pkg::paddr_t        o_fetch_addr
);

    import fetch_pkg::*;

    // Program counter register
    pc_word_t pc_q;
    // Sequential successor
    pc_word_t pc_seq;
    // Word address after optional remap
    pc_word_t xlate_word;

    assign pc_seq = pc_q + 30'd1;

    // Redirect beats advance when both land together
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC_WORD;
        end else if (i_redirect) begin
            pc_q <= i_redirect_pc_word;
        end else if (i_pc_advance) begin
            // Sequencer has latched the old pc, move on
            pc_q <= pc_seq;
        end
    end

    // Base-offset translation
    // Adds the base word to the virtual word when enabled
    always_comb begin
        if (i_xlate_en) begin
            xlate_word = pc_q + i_xlate_base_word;
        end else begin
            xlate_word = pc_q;
        end
    end

    // Reported pc always stays untranslated
    assign o_pc_word = pc_q;

    // Byte form of the translated word, always word aligned
    assign o_fetch_addr = {xlate_word, 2'b00};

endmodule : fetch_stage_f1

`default_nettype wire

// ==== fetch_ack_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_ack_timer #(
    // Cycles of waiting for ack before a fault
    parameter int unsigned TIMEOUT_CYCLES = 8
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,

    // High while a request waits for ack
    input  wire logic i_run,

    // Wait limit reached
    output logic      o_timeout
);

    // Counter wide enough to hold the limit itself
    localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    // Limit in counter width
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(TIMEOUT_CYCLES);

    // Cycles spent waiting so far
    logic [CNT_W-1:0] count_q;

    // Saturating up counter
    // Cleared whenever the request is not waiting
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            count_q <= '0;
        end else if (!i_run) begin
            count_q <= '0;
        end else if (count_q != LIMIT) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Stays high while saturated and running
    // Cleared count never matches, so an idle bus shows no timeout
    assign o_timeout = (count_q == LIMIT);

endmodule : fetch_ack_timer

`default_nettype wire

// ==== fetch_req_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_req_fsm (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,

    // Redirect marks the open transaction stale
    input  wire logic                i_redirect,

    // Current pc and address from F1
    input  wire fetch_pkg::pc_word_t i_pc_word,
    input  wire fetch_pkg::paddr_t   i_fetch_addr,
    output logic                     o_pc_advance,

    // Four-phase memory bus
    output logic                     o_mem_req,
    output fetch_pkg::paddr_t        o_mem_addr,
    input  wire logic                i_mem_ack,
    input  wire fetch_pkg::instr_t   i_mem_rdata,

    // Ack watchdog
    output logic                     o_timer_run,
    input  wire logic                i_timeout,

    // F2 hand-off
    input  wire logic                i_slot_free,
    output logic                     o_f2_load,
    output fetch_pkg::pc_word_t      o_f2_pc_word,
    output fetch_pkg::instr_t        o_f2_instr,
    output logic                     o_f2_fault
);

    import fetch_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;

    // Pc and address of the open transaction
    pc_word_t pc_q;
    paddr_t   addr_q;

    // Set by a redirect while a transaction is open
    logic stale_q;

    // Issue a request this cycle
    logic issue;
    // First ack-high cycle in REQ
    logic ack_take;
    // Watchdog fired before any ack
    logic to_take;

    // F2 must be empty after this edge before a request goes out
    assign issue    = (state_q == IDLE) && i_slot_free && !i_redirect;
    assign ack_take = (state_q == REQ) && i_mem_ack;
    assign to_take  = (state_q == REQ) && !i_mem_ack && i_timeout;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (issue) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                // Ack wins over a timeout in the same cycle
                if (ack_take) begin
                    state_d = RELEASE;
                end else if (to_take) begin
                    state_d = ABORT;
                end
            end
            // Both wait for ack low before the bus may be reused
            RELEASE, ABORT: begin
                if (!i_mem_ack) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            stale_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (issue) begin
                // Fresh transaction starts clean
                stale_q <= 1'b0;
            end else if (i_redirect && (state_q != IDLE)) begin
                stale_q <= 1'b1;
            end
        end
    end

    // Request payload, held for the whole transaction
    always_ff @(posedge i_clk) begin
        if (issue) begin
            pc_q   <= i_pc_word;
            addr_q <= i_fetch_addr;
        end
    end

    // F1 steps on at the same edge the request is latched
    assign o_pc_advance = issue;

    assign o_mem_req   = (state_q == REQ);
    assign o_mem_addr  = addr_q;
    assign o_timer_run = (state_q == REQ);

    // Stale or redirected data never reaches F2
    assign o_f2_load    = (ack_take || to_take) && !stale_q && !i_redirect;
    assign o_f2_pc_word = pc_q;
    // Fault item carries a zero instruction
    assign o_f2_instr   = to_take ? '0 : i_mem_rdata;
    assign o_f2_fault   = to_take;

endmodule : fetch_req_fsm

`default_nettype wire

// ==== fetch_stage_f2.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage_f2 (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,

    // Redirect empties the stage
    input  wire logic                i_flush,

    // Item from the sequencer
    input  wire logic                i_load,
    input  wire fetch_pkg::pc_word_t i_pc_word,
    input  wire fetch_pkg::instr_t   i_instr,
    input  wire logic                i_fault,

    // Empty, or handing its item to decode this cycle
    output logic                     o_slot_free,

    // Toward decode
    output logic                     o_dec_valid,
    output fetch_pkg::pc_word_t      o_dec_pc_word,
    output fetch_pkg::instr_t        o_dec_instr,
    output logic                     o_dec_fault,
    input  wire logic                i_dec_ready
);

    import fetch_pkg::*;

    logic     valid_q;
    pc_word_t pc_q;
    instr_t   instr_q;
    logic     fault_q;

    // Load accepted this cycle
    logic take;
    // Item leaves toward decode this cycle
    logic xfer;

    assign xfer        = valid_q && i_dec_ready;
    assign o_slot_free = !valid_q || i_dec_ready;

    // A load into a full, stalled register would lose an item
    assign take = i_load && o_slot_free && !i_flush;

    // Valid bit, flush first
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end else if (take) begin
            // New item may replace one leaving this cycle
            valid_q <= 1'b1;
        end else if (xfer) begin
            valid_q <= 1'b0;
        end
    end

    // Fault flag is low out of reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            fault_q <= 1'b0;
        end else if (take) begin
            fault_q <= i_fault;
        end
    end

    // Pc and instruction only change on a load
    // Stable under back-pressure
    always_ff @(posedge i_clk) begin
        if (take) begin
            pc_q    <= i_pc_word;
            instr_q <= i_instr;
        end
    end

    assign o_dec_valid   = valid_q;
    assign o_dec_pc_word = pc_q;
    assign o_dec_instr   = instr_q;
    assign o_dec_fault   = fault_q;

endmodule : fetch_stage_f2

`default_nettype wire

// ==== fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::pc_word_t RESET_PC_WORD  = 30'h0,
    parameter int unsigned         TIMEOUT_CYCLES = 8
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,

    // Branch redirect
    input  wire logic                i_redirect,
    input  wire fetch_pkg::pc_word_t i_redirect_pc_word,

    // Base-offset translation
    input  wire logic                i_xlate_en,
    input  wire fetch_pkg::pc_word_t i_xlate_base_word,

    // Instruction memory, four-phase req/ack
    output logic                     o_mem_req,
    output fetch_pkg::paddr_t        o_mem_addr,
    input  wire logic                i_mem_ack,
    input  wire fetch_pkg::instr_t   i_mem_rdata,

    // Decode, valid/ready
    output logic                     o_dec_valid,
    output fetch_pkg::pc_word_t      o_dec_pc_word,
    output fetch_pkg::instr_t        o_dec_instr,
    output logic                     o_dec_fault,
    input  wire logic                i_dec_ready
);

    import fetch_pkg::*;

    // F1 to sequencer
    pc_word_t pc_word;
    paddr_t   fetch_addr;
    logic     pc_advance;

    // Sequencer and watchdog
    logic timer_run;
    logic timeout;

    // Sequencer to F2
    logic     slot_free;
    logic     f2_load;
    pc_word_t f2_pc_word;
    instr_t   f2_instr;
    logic     f2_fault;

    fetch_stage_f1 #(
        .RESET_PC_WORD      (RESET_PC_WORD)
    ) u_f1 (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_redirect         (i_redirect),
        .i_redirect_pc_word (i_redirect_pc_word),
        .i_pc_advance       (pc_advance),
        .i_xlate_en         (i_xlate_en),
        .i_xlate_base_word  (i_xlate_base_word),
        .o_pc_word          (pc_word),
        .o_fetch_addr       (fetch_addr)
    );

    fetch_req_fsm u_req (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_redirect   (i_redirect),
        .i_pc_word    (pc_word),
        .i_fetch_addr (fetch_addr),
        .o_pc_advance (pc_advance),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ack    (i_mem_ack),
        .i_mem_rdata  (i_mem_rdata),
        .o_timer_run  (timer_run),
        .i_timeout    (timeout),
        .i_slot_free  (slot_free),
        .o_f2_load    (f2_load),
        .o_f2_pc_word (f2_pc_word),
        .o_f2_instr   (f2_instr),
        .o_f2_fault   (f2_fault)
    );

    fetch_ack_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_timer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_run     (timer_run),
        .o_timeout (timeout)
    );

    // Redirect doubles as the F2 flush
    fetch_stage_f2 u_f2 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_redirect),
        .i_load        (f2_load),
        .i_pc_word     (f2_pc_word),
        .i_instr       (f2_instr),
        .i_fault       (f2_fault),
        .o_slot_free   (slot_free),
        .o_dec_valid   (o_dec_valid),
        .o_dec_pc_word (o_dec_pc_word),
        .o_dec_instr   (o_dec_instr),
        .o_dec_fault   (o_dec_fault),
        .i_dec_ready   (i_dec_ready)
    );

endmodule : fetch_top

`default_nettype wire

// ==== fetch_top_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top_chk (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,

    // Front end control seen inside fetch_top
    input  wire logic                i_redirect,
    input  wire logic                i_timeout,

    // Memory side
    input  wire logic                i_mem_req,
    input  wire fetch_pkg::paddr_t   i_mem_addr,
    input  wire logic                i_mem_ack,

    // Decode side
    input  wire logic                i_dec_valid,
    input  wire fetch_pkg::pc_word_t i_dec_pc_word,
    input  wire fetch_pkg::instr_t   i_dec_instr,
    input  wire logic                i_dec_fault,
    input  wire logic                i_dec_ready
);

    // Count of failed assertions
    int unsigned fail_count = 0;

    // Req held until ack, watchdog abort excepted
    a_req_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem_req && !i_mem_ack && !i_timeout) |=> i_mem_req)
        else begin
            $error("mem req dropped before ack");
            fail_count = fail_count + 1;
        end

    // No new req while the previous ack is still high
    a_req_after_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_mem_req && i_mem_ack) |=> !i_mem_req)
        else begin
            $error("mem req rose while ack high");
            fail_count = fail_count + 1;
        end

    // Address frozen for the whole request phase
    a_addr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mem_req |=> (!i_mem_req || $stable(i_mem_addr)))
        else begin
            $error("mem addr changed while req high");
            fail_count = fail_count + 1;
        end

    // Stalled item held, unless a redirect flushes it
    a_dec_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_dec_valid && !i_dec_ready && !i_redirect) |=>
        (i_dec_valid && $stable(i_dec_pc_word) && $stable(i_dec_instr)
            && $stable(i_dec_fault)))
        else begin
            $error("decode item changed under back-pressure");
            fail_count = fail_count + 1;
        end

endmodule : fetch_top_chk

// Watchdog output taken from inside the top level
bind fetch_top fetch_top_chk u_chk (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_redirect    (i_redirect),
    .i_timeout     (timeout),
    .i_mem_req     (o_mem_req),
    .i_mem_addr    (o_mem_addr),
    .i_mem_ack     (i_mem_ack),
    .i_dec_valid   (o_dec_valid),
    .i_dec_pc_word (o_dec_pc_word),
    .i_dec_instr   (o_dec_instr),
    .i_dec_fault   (o_dec_fault),
    .i_dec_ready   (i_dec_ready)
);

`default_nettype wire

// ==== tb_fetch_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_mem #(
    // First byte address that never answers
    parameter fetch_pkg::paddr_t UNMAPPED_BASE = 32'h0001_0000
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_req,
    input  wire fetch_pkg::paddr_t i_addr,
    output logic                   o_ack,
    output fetch_pkg::instr_t      o_rdata
);

    import fetch_pkg::*;

    // Request seen, ack delay running
    logic       pending_q;
    // Remaining wait cycles
    logic [1:0] delay_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack     <= 1'b0;
            o_rdata   <= '0;
            pending_q <= 1'b0;
            delay_q   <= '0;
        end else if (o_ack) begin
            // Return to zero once req has fallen
            if (!i_req) begin
                o_ack <= 1'b0;
            end
        end else if (!i_req) begin
            // Req withdrawn, e.g. after a watchdog abort
            pending_q <= 1'b0;
        end else if (!pending_q) begin
            pending_q <= 1'b1;
            delay_q   <= 2'($urandom % 32'd4);
        end else if (delay_q != 2'd0) begin
            delay_q <= delay_q - 2'd1;
        end else if (i_addr < UNMAPPED_BASE) begin
            // Unmapped addresses just sit here forever
            o_ack     <= 1'b1;
            o_rdata   <= i_addr ^ MEM_SALT;
            pending_q <= 1'b0;
        end
    end

endmodule : tb_fetch_mem

`default_nettype wire

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top;

    import fetch_pkg::*;

    localparam pc_word_t    RESET_PC_WORD  = 30'h40;
    localparam int unsigned TIMEOUT_CYCLES = 8;
    localparam paddr_t      UNMAPPED_BASE  = 32'h0001_0000;
    localparam int          N_ROWS         = 7;
    localparam logic [31:0] SEED           = 32'h55f4186e;

    logic     clk;
    logic     rst_n;
    logic     redirect;
    pc_word_t redirect_pc_word;
    logic     xlate_en;
    pc_word_t xlate_base_word;
    logic     mem_req;
    paddr_t   mem_addr;
    logic     mem_ack;
    instr_t   mem_rdata;
    logic     dec_valid;
    pc_word_t dec_pc_word;
    instr_t   dec_instr;
    logic     dec_fault;
    logic     dec_ready;

    // Stimulus table, one entry per row
    logic        row_redir [N_ROWS];
    pc_word_t    row_target [N_ROWS];
    logic        row_xen [N_ROWS];
    pc_word_t    row_base [N_ROWS];
    int unsigned row_count [N_ROWS];
    logic        row_stall [N_ROWS];

    // Next pc decode should see
    pc_word_t    exp_pc;
    int unsigned checks;
    int unsigned errors;
    int unsigned cycles;
    int unsigned cycle_limit;

    fetch_top #(
        .RESET_PC_WORD  (RESET_PC_WORD),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) DUT (
        .i_clk              (clk),
        .i_rst_n            (rst_n),
        .i_redirect         (redirect),
        .i_redirect_pc_word (redirect_pc_word),
        .i_xlate_en         (xlate_en),
        .i_xlate_base_word  (xlate_base_word),
        .o_mem_req          (mem_req),
        .o_mem_addr         (mem_addr),
        .i_mem_ack          (mem_ack),
        .i_mem_rdata        (mem_rdata),
        .o_dec_valid        (dec_valid),
        .o_dec_pc_word      (dec_pc_word),
        .o_dec_instr        (dec_instr),
        .o_dec_fault        (dec_fault),
        .i_dec_ready        (dec_ready)
    );

    tb_fetch_mem #(
        .UNMAPPED_BASE (UNMAPPED_BASE)
    ) u_mem (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_req   (mem_req),
        .i_addr  (mem_addr),
        .o_ack   (mem_ack),
        .o_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic set_row(input int idx, input logic redir, input pc_word_t target,
                           input logic xen, input pc_word_t base,
                           input int unsigned count, input logic stall);
        row_redir[idx]  = redir;
        row_target[idx] = target;
        row_xen[idx]    = xen;
        row_base[idx]   = base;
        row_count[idx]  = count;
        row_stall[idx]  = stall;
    endtask

    // Byte address memory sees for a given pc
    function automatic paddr_t fetch_byte_addr(input pc_word_t pc, input logic xen,
                                               input pc_word_t base);
        pc_word_t w;
        w = xen ? pc + base : pc;
        return {w, 2'b00};
    endfunction

    function automatic logic pick_ready(input logic stall);
        return stall ? 1'($urandom % 32'd2) : 1'b1;
    endfunction

    task automatic check_item(input int row);
        paddr_t addr;
        logic   exp_fault;
        instr_t exp_instr;
        addr      = fetch_byte_addr(exp_pc, row_xen[row], row_base[row]);
        // Unmapped fetch ends as a watchdog fault
        exp_fault = (addr >= UNMAPPED_BASE);
        exp_instr = exp_fault ? '0 : (addr ^ MEM_SALT);
        checks    = checks + 1;
        assert (dec_pc_word == exp_pc) else begin
            $display("[FAIL] %0t ns row %0d: pc %h, expected %h", $time, row, dec_pc_word, exp_pc);
            errors = errors + 1;
        end
        assert (dec_instr == exp_instr) else begin
            $display("[FAIL] %0t ns row %0d: instr %h, expected %h", $time, row, dec_instr,
                     exp_instr);
            errors = errors + 1;
        end
        assert (dec_fault == exp_fault) else begin
            $display("[FAIL] %0t ns row %0d: fault %b, expected %b", $time, row, dec_fault,
                     exp_fault);
            errors = errors + 1;
        end
    endtask

    initial begin
        int unsigned taken;
        int unsigned err_start;
        void'($urandom(SEED));
        rst_n            = 1'b0;
        redirect         = 1'b0;
        redirect_pc_word = '0;
        xlate_en         = 1'b0;
        xlate_base_word  = '0;
        dec_ready        = 1'b0;
        checks           = 0;
        errors           = 0;
        cycles           = 0;
        // Reset sequence, stalls, redirect, remap, unmapped, boundary, recovery
        set_row(0, 1'b0, 30'h0,    1'b0, 30'h0,  6,  1'b0);
        set_row(1, 1'b0, 30'h0,    1'b0, 30'h0,  10, 1'b1);
        set_row(2, 1'b1, 30'h200,  1'b0, 30'h0,  6,  1'b0);
        set_row(3, 1'b1, 30'h300,  1'b1, 30'h80, 8,  1'b1);
        set_row(4, 1'b1, 30'h4000, 1'b0, 30'h0,  3,  1'b0);
        set_row(5, 1'b1, 30'h3ffe, 1'b0, 30'h0,  4,  1'b1);
        set_row(6, 1'b1, 30'h80,   1'b0, 30'h0,  5,  1'b1);
        cycle_limit = 200;
        for (int r = 0; r < N_ROWS; r++) begin
            cycle_limit = cycle_limit + row_count[r] * (TIMEOUT_CYCLES + 8);
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        exp_pc = RESET_PC_WORD;
        for (int r = 0; r < N_ROWS; r++) begin
            err_start = errors;
            taken     = 0;
            @(posedge clk);
            if (row_redir[r]) begin
                // Decode held off during the flush cycle
                redirect         <= 1'b1;
                redirect_pc_word <= row_target[r];
                xlate_en         <= row_xen[r];
                xlate_base_word  <= row_base[r];
                dec_ready        <= 1'b0;
                exp_pc = row_target[r];
                @(posedge clk);
                redirect <= 1'b0;
            end
            dec_ready <= pick_ready(row_stall[r]);
            while (taken < row_count[r]) begin
                // Transfer seen mid-cycle completes at the next edge
                @(negedge clk);
                if (dec_valid && dec_ready) begin
                    check_item(r);
                    taken  = taken + 1;
                    exp_pc = exp_pc + 30'd1;
                end
                @(posedge clk);
                dec_ready <= (taken < row_count[r]) ? pick_ready(row_stall[r]) : 1'b0;
            end
            $display("Row %0d done: %0d items, %0d errors", r, taken, errors - err_start);
        end
        $display("Rows %0d, checks %0d, errors %0d, assertion failures %0d", N_ROWS, checks,
                 errors, DUT.u_chk.fail_count);
        if ((errors == 0) && (DUT.u_chk.fail_count == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_fetch_top

`default_nettype wire

// ==== sim.f ====
fetch_pkg.sv
fetch_stage_f1.sv
fetch_ack_timer.sv
fetch_req_fsm.sv
fetch_stage_f2.sv
fetch_top.sv
fetch_top_chk.sv
tb_fetch_mem.sv
tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - fetch_pkg.sv
  - fetch_stage_f1.sv
  - fetch_ack_timer.sv
  - fetch_req_fsm.sv
  - fetch_stage_f2.sv
  - fetch_top.sv
  - target: simulation
    files:
      - fetch_top_chk.sv
      - tb_fetch_mem.sv
      - tb_fetch_top.sv
